// ==== hw/index_calc.sv ====
////////////////////////////////////////////////////////////
// Index calculator
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module index_calc (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               in_valid,
	input  logic                               in_last,
	input  logic                               hold,
	input  logic                               swap,
	input  logic                               sign,
	input  logic [index_pkg::INDEX_WIDTH-1:0]  raw_index,
	input  logic [index_pkg::INDEX_WIDTH-1:0]  constant,
	input  logic [index_pkg::INDEX_WIDTH-1:0]  lane,
	input  logic [index_pkg::THREAD_WIDTH-1:0] thread,
	input  logic [index_pkg::SEL_WIDTH-1:0]    sel_a,
	input  logic [index_pkg::SEL_WIDTH-1:0]    sel_b,
	input  logic [index_pkg::SEL_WIDTH-1:0]    sel_c,
	output logic                               out_valid,
	output logic                               out_last,
	output logic [index_pkg::INDEX_WIDTH-1:0]  out_index
);

	logic [index_pkg::INDEX_WIDTH-1:0] thread_ext;
	logic [index_pkg::INDEX_WIDTH-1:0] op_a;
	logic [index_pkg::INDEX_WIDTH-1:0] op_b;
	logic [index_pkg::INDEX_WIDTH-1:0] op_c;
	logic [index_pkg::INDEX_WIDTH-1:0] prod;
	logic [index_pkg::INDEX_WIDTH-1:0] s1;
	logic [index_pkg::INDEX_WIDTH-1:0] s2;
	logic [index_pkg::INDEX_WIDTH-1:0] result;

	assign thread_ext = {{(index_pkg::INDEX_WIDTH - index_pkg::THREAD_WIDTH){1'b0}}, thread};

	////////////////////////////////////////////////////////////
	// Operand tables

	always_comb begin
		case (sel_a)
			index_pkg::SEL_THREAD: op_a = thread_ext;
			index_pkg::SEL_CONST:  op_a = constant;
			index_pkg::SEL_RAW:    op_a = raw_index;
			default:               op_a = '0;
		endcase
		case (sel_b)
			index_pkg::SEL_THREAD: op_b = '0;   // No thread term on b
			index_pkg::SEL_CONST:  op_b = constant;
			index_pkg::SEL_RAW:    op_b = raw_index;
			default:               op_b = lane;
		endcase
		case (sel_c)
			index_pkg::SEL_THREAD: op_c = thread_ext;
			index_pkg::SEL_CONST:  op_c = constant;
			index_pkg::SEL_RAW:    op_c = raw_index;
			default:               op_c = lane;
		endcase
	end

	// Multiply-add/subtract wrapping at index width
	assign prod   = op_a * op_b;
	assign s1     = swap ? op_c : prod;
	assign s2     = swap ? prod : op_c;
	assign result = sign ? s1 - s2 : s1 + s2;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else if (!hold) begin
			out_valid <= in_valid;
			out_last  <= in_valid & in_last;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold && in_valid) begin
			out_index <= result;
		end
	end

endmodule

// ==== hw/index_pkg.sv ====
////////////////////////////////////////////////////////////
// Index unit shared constants
////////////////////////////////////////////////////////////

package index_pkg;

	////////////////////////////////////////////////////////////
	// Widths

	// Indices, window, length, constant and results
	localparam int INDEX_WIDTH  = 8;

	localparam int THREAD_WIDTH = 4;   // Thread ID

	// Activity mask width and longest masked run
	localparam int MASK_WIDTH   = 16;

	////////////////////////////////////////////////////////////
	// Command modes

	localparam int MODE_WIDTH = 2;

	localparam logic [MODE_WIDTH-1:0] MODE_SINGLE = 2'd0;   // One index at base
	localparam logic [MODE_WIDTH-1:0] MODE_SLICE  = 2'd1;   // Wrapping run in a window
	localparam logic [MODE_WIDTH-1:0] MODE_MASKED = 2'd2;   // One index per set mask bit

	////////////////////////////////////////////////////////////
	// Operand select codes

	localparam int SEL_WIDTH = 2;

	// Operand b reads zero for SEL_THREAD
	localparam logic [SEL_WIDTH-1:0] SEL_THREAD    = 2'd0;
	localparam logic [SEL_WIDTH-1:0] SEL_CONST     = 2'd1;
	localparam logic [SEL_WIDTH-1:0] SEL_RAW       = 2'd2;   // Raw index of the item

	// Zero on operand a, lane number on b and c
	localparam logic [SEL_WIDTH-1:0] SEL_LANE_ZERO = 2'd3;

endpackage

// ==== hw/index_unit.sv ====
////////////////////////////////////////////////////////////
// Lane index generation unit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module index_unit #(
	parameter int lane_id = 0
) (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               cmd_req,
	output logic                               cmd_ack,
	input  logic [index_pkg::MODE_WIDTH-1:0]   cmd_mode,
	input  logic [index_pkg::INDEX_WIDTH-1:0]  cmd_base,
	input  logic [index_pkg::INDEX_WIDTH-1:0]  cmd_window,
	input  logic [index_pkg::INDEX_WIDTH-1:0]  cmd_length,
	input  logic [index_pkg::INDEX_WIDTH-1:0]  cmd_const,
	input  logic [index_pkg::THREAD_WIDTH-1:0] cmd_thread,
	input  logic [index_pkg::SEL_WIDTH-1:0]    cmd_sel_a,
	input  logic [index_pkg::SEL_WIDTH-1:0]    cmd_sel_b,
	input  logic [index_pkg::SEL_WIDTH-1:0]    cmd_sel_c,
	input  logic                               cmd_swap,
	input  logic                               cmd_sign,
	input  logic [index_pkg::MASK_WIDTH-1:0]   cmd_mask,
	input  logic                               stall,
	output logic                               out_valid,
	output logic                               out_last,
	output logic [index_pkg::INDEX_WIDTH-1:0]  out_index,
	output logic                               busy
);

	typedef enum logic [1:0] {st_idle, st_run, st_ack, st_release} state_t;

	state_t state;

	// Captured command
	logic [index_pkg::INDEX_WIDTH-1:0]  base_q;
	logic [index_pkg::INDEX_WIDTH-1:0]  window_q;
	logic [index_pkg::INDEX_WIDTH-1:0]  length_q;
	logic [index_pkg::INDEX_WIDTH-1:0]  const_q;
	logic [index_pkg::THREAD_WIDTH-1:0] thread_q;
	logic [index_pkg::SEL_WIDTH-1:0]    sel_a_q;
	logic [index_pkg::SEL_WIDTH-1:0]    sel_b_q;
	logic [index_pkg::SEL_WIDTH-1:0]    sel_c_q;
	logic                               swap_q;
	logic                               sign_q;
	logic [index_pkg::MASK_WIDTH-1:0]   mask_q;

	logic                               capture;
	logic                               slice_start;
	logic                               skip_start;
	logic                               slice_none;   // Slice run with zero length
	logic                               advance;
	logic                               hold;
	logic                               done;

	logic                               slice_valid;
	logic                               slice_last;
	logic [index_pkg::INDEX_WIDTH-1:0]  slice_index;
	logic                               skip_valid;
	logic                               skip_last;
	logic [index_pkg::INDEX_WIDTH-1:0]  skip_index;
	logic                               skip_empty;

	logic                               raw_valid;
	logic                               raw_last;
	logic [index_pkg::INDEX_WIDTH-1:0]  raw_index;
	logic [index_pkg::INDEX_WIDTH-1:0]  lane;

	assign capture = (state == st_idle) && cmd_req;
	assign hold    = stall & out_valid;   // Whole pipeline freezes together
	assign advance = ~hold;
	assign done    = (out_valid & out_last & ~stall) | skip_empty | slice_none;
	assign lane    = lane_id[index_pkg::INDEX_WIDTH-1:0];

	assign cmd_ack = state == st_ack;
	assign busy    = state != st_idle;

	////////////////////////////////////////////////////////////
	// Handshake FSM

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:    if (cmd_req) state <= st_run;
				st_run:     if (done) state <= st_ack;
				st_ack:     if (!cmd_req) state <= st_release;   // Ack drops here
				default:    state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			slice_start <= 1'b0;
			skip_start  <= 1'b0;
			slice_none  <= 1'b0;
		end else begin
			slice_start <= capture && (cmd_mode != index_pkg::MODE_MASKED);
			skip_start  <= capture && (cmd_mode == index_pkg::MODE_MASKED);
			slice_none  <= slice_start && (length_q == '0);
		end
	end

	////////////////////////////////////////////////////////////
	// Command capture

	always_ff @(posedge clock) begin
		if (capture) begin
			base_q   <= cmd_base;
			const_q  <= cmd_const;
			thread_q <= cmd_thread;
			sel_a_q  <= cmd_sel_a;
			sel_b_q  <= cmd_sel_b;
			sel_c_q  <= cmd_sel_c;
			swap_q   <= cmd_swap;
			sign_q   <= cmd_sign;
			mask_q   <= cmd_mask;
			case (cmd_mode)
				index_pkg::MODE_SINGLE: begin   // Slice of one
					window_q <= 8'd1;
					length_q <= 8'd1;
				end
				index_pkg::MODE_SLICE, index_pkg::MODE_MASKED: begin
					window_q <= cmd_window;
					length_q <= cmd_length;
				end
				default: begin   // Unknown mode yields no indices
					window_q <= 8'd1;
					length_q <= '0;
				end
			endcase
		end
	end

	slice_sequencer u_slice (
		.clock     (clock),
		.reset     (reset),
		.start     (slice_start),
		.advance   (advance),
		.base      (base_q),
		.window    (window_q),
		.length    (length_q),
		.raw_valid (slice_valid),
		.raw_last  (slice_last),
		.raw_index (slice_index)
	);

	mask_skipper u_skip (
		.clock     (clock),
		.reset     (reset),
		.start     (skip_start),
		.advance   (advance),
		.base      (base_q),
		.length    (length_q),
		.mask      (mask_q),
		.raw_valid (skip_valid),
		.raw_last  (skip_last),
		.raw_index (skip_index),
		.empty     (skip_empty)
	);

	// Only one source runs per command
	assign raw_valid = slice_valid | skip_valid;
	assign raw_last  = slice_valid ? slice_last : skip_last;
	assign raw_index = skip_valid ? skip_index : slice_index;

	index_calc u_calc (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (raw_valid),
		.in_last   (raw_last),
		.hold      (hold),
		.swap      (swap_q),
		.sign      (sign_q),
		.raw_index (raw_index),
		.constant  (const_q),
		.lane      (lane),
		.thread    (thread_q),
		.sel_a     (sel_a_q),
		.sel_b     (sel_b_q),
		.sel_c     (sel_c_q),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_index (out_index)
	);

endmodule

// ==== hw/mask_skipper.sv ====
////////////////////////////////////////////////////////////
// Masked index skipper
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mask_skipper (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              start,
	input  logic                              advance,
	input  logic [index_pkg::INDEX_WIDTH-1:0] base,
	input  logic [index_pkg::INDEX_WIDTH-1:0] length,
	input  logic [index_pkg::MASK_WIDTH-1:0]  mask,
	output logic                              raw_valid,
	output logic                              raw_last,
	output logic [index_pkg::INDEX_WIDTH-1:0] raw_index,
	output logic                              empty
);

	logic [index_pkg::MASK_WIDTH-1:0]  keep;       // Positions below length
	logic [index_pkg::MASK_WIDTH-1:0]  remain;     // Bits not yet emitted
	logic [index_pkg::MASK_WIDTH-1:0]  src;
	logic [index_pkg::MASK_WIDTH-1:0]  rest;
	logic [index_pkg::INDEX_WIDTH-1:0] pos;
	logic                              found;
	logic                              step;

	////////////////////////////////////////////////////////////
	// Mask trim and priority encoder

	always_comb begin
		for (int p = 0; p < index_pkg::MASK_WIDTH; p++) begin
			keep[p] = p < int'(length);
		end
	end

	// Fresh trimmed mask at start, leftover bits otherwise
	assign src   = start ? (mask & keep) : remain;
	assign found = |src;
	assign rest  = src & (src - 1'b1);   // Lowest set bit cleared

	// Lowest set position wins
	always_comb begin
		pos = '0;
		for (int i = index_pkg::MASK_WIDTH - 1; i >= 0; i--) begin
			if (src[i]) begin
				pos = i[index_pkg::INDEX_WIDTH-1:0];
			end
		end
	end

	assign step = start | advance;

	////////////////////////////////////////////////////////////
	// Control state

	always_ff @(posedge clock) begin
		if (reset) begin
			raw_valid <= 1'b0;
			raw_last  <= 1'b0;
			remain    <= '0;
			empty     <= 1'b0;
		end else begin
			empty <= start & ~found;   // One-cycle pulse for a zero mask
			if (step) begin
				raw_valid <= found;
				raw_last  <= found & (rest == '0);
				remain    <= rest;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (step && found) begin
			raw_index <= base + pos;
		end
	end

endmodule

// ==== hw/slice_sequencer.sv ====
////////////////////////////////////////////////////////////
// Slice index sequencer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module slice_sequencer (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              start,
	input  logic                              advance,
	input  logic [index_pkg::INDEX_WIDTH-1:0] base,
	input  logic [index_pkg::INDEX_WIDTH-1:0] window,
	input  logic [index_pkg::INDEX_WIDTH-1:0] length,
	output logic                              raw_valid,
	output logic                              raw_last,
	output logic [index_pkg::INDEX_WIDTH-1:0] raw_index
);

	logic [index_pkg::INDEX_WIDTH-1:0] offset;        // Window offset of next index
	logic [index_pkg::INDEX_WIDTH-1:0] count;         // Indices issued so far
	logic                              active;        // Indices left after the held one

	logic [index_pkg::INDEX_WIDTH-1:0] from_offset;
	logic [index_pkg::INDEX_WIDTH-1:0] from_count;
	logic                              emit;
	logic                              at_last;
	logic                              win_end;
	logic                              step;

	////////////////////////////////////////////////////////////
	// Next index selection

	// A start restarts both counters from zero
	assign from_offset = start ? '0 : offset;
	assign from_count  = start ? '0 : count;

	// Zero length never emits
	assign emit    = start ? (length != '0) : active;
	assign at_last = (from_count + 1'b1) == length;

	// Window of zero behaves like a window of one
	assign win_end = (window == '0) || (from_offset == window - 1'b1);

	assign step = start | advance;

	////////////////////////////////////////////////////////////
	// Control state

	always_ff @(posedge clock) begin
		if (reset) begin
			raw_valid <= 1'b0;
			raw_last  <= 1'b0;
			active    <= 1'b0;
		end else if (step) begin
			raw_valid <= emit;
			raw_last  <= emit & at_last;
			active    <= emit & ~at_last;   // Idle after the final index
		end
	end

	////////////////////////////////////////////////////////////
	// Counters and index payload

	always_ff @(posedge clock) begin
		if (step && emit) begin
			raw_index <= base + from_offset;
			offset    <= win_end ? '0 : from_offset + 1'b1;   // Wrap at window end
			count     <= from_count + 1'b1;
		end
	end

endmodule

// ==== index_unit.f ====
hw/index_pkg.sv
hw/slice_sequencer.sv
hw/mask_skipper.sv
hw/index_calc.sv
hw/index_unit.sv
verif/index_unit_asserts.sv
verif/index_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the index unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f index_unit.f --top-module index_unit_tb -o index_unit_sim

sim_status=0
./obj_dir/index_unit_sim +verilator+error+limit+100 > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi
if [ "$sim_status" -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi
echo "Simulation finished without failures"

// ==== verif/index_unit_asserts.sv ====
////////////////////////////////////////////////////////////
// Index unit handshake and stall checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module index_unit_asserts (
	input logic                              clock,
	input logic                              reset,
	input logic                              cmd_req,
	input logic                              cmd_ack,
	input logic                              stall,
	input logic                              out_valid,
	input logic [index_pkg::INDEX_WIDTH-1:0] out_index,
	input logic                              busy
);

	int unsigned failures = 0;   // Read by the testbench at the end

	// Output item frozen while stalled
	assert property (@(posedge clock) disable iff (reset)
		(stall && out_valid) |=> ($stable(out_valid) && $stable(out_index)))
	else begin
		failures++;
		$error("Output changed while stall was high");
	end

	// Ack stays up until req is gone
	assert property (@(posedge clock) disable iff (reset)
		(cmd_ack && cmd_req) |=> cmd_ack)
	else begin
		failures++;
		$error("cmd_ack fell while cmd_req was still high");
	end

	assert property (@(posedge clock) reset |=> !busy)
	else begin
		failures++;
		$error("busy high in the cycle after reset");
	end

endmodule

bind index_unit index_unit_asserts u_asserts (
	.clock     (clock),
	.reset     (reset),
	.cmd_req   (cmd_req),
	.cmd_ack   (cmd_ack),
	.stall     (stall),
	.out_valid (out_valid),
	.out_index (out_index),
	.busy      (busy)
);

// ==== verif/index_unit_tb.sv ====
////////////////////////////////////////////////////////////
// Index unit testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module index_unit_tb;

	localparam int test_lane = 3;

	typedef struct {
		logic [index_pkg::MODE_WIDTH-1:0]   mode;
		logic [index_pkg::INDEX_WIDTH-1:0]  base;
		logic [index_pkg::INDEX_WIDTH-1:0]  window;
		logic [index_pkg::INDEX_WIDTH-1:0]  length;
		logic [index_pkg::INDEX_WIDTH-1:0]  konst;
		logic [index_pkg::THREAD_WIDTH-1:0] thread;
		logic [index_pkg::SEL_WIDTH-1:0]    sel_a;
		logic [index_pkg::SEL_WIDTH-1:0]    sel_b;
		logic [index_pkg::SEL_WIDTH-1:0]    sel_c;
		logic                               swap;
		logic                               sign;
		logic [index_pkg::MASK_WIDTH-1:0]   mask;
		logic                               rand_stall;   // Random stall on this row
		int                                 count;        // Expected number of indices
	} cmd_row_t;

	logic                               clock;
	logic                               reset;
	logic                               cmd_req;
	logic                               cmd_ack;
	logic [index_pkg::MODE_WIDTH-1:0]   cmd_mode;
	logic [index_pkg::INDEX_WIDTH-1:0]  cmd_base;
	logic [index_pkg::INDEX_WIDTH-1:0]  cmd_window;
	logic [index_pkg::INDEX_WIDTH-1:0]  cmd_length;
	logic [index_pkg::INDEX_WIDTH-1:0]  cmd_const;
	logic [index_pkg::THREAD_WIDTH-1:0] cmd_thread;
	logic [index_pkg::SEL_WIDTH-1:0]    cmd_sel_a;
	logic [index_pkg::SEL_WIDTH-1:0]    cmd_sel_b;
	logic [index_pkg::SEL_WIDTH-1:0]    cmd_sel_c;
	logic                               cmd_swap;
	logic                               cmd_sign;
	logic [index_pkg::MASK_WIDTH-1:0]   cmd_mask;
	logic                               stall;
	logic                               out_valid;
	logic                               out_last;
	logic [index_pkg::INDEX_WIDTH-1:0]  out_index;
	logic                               busy;

	cmd_row_t                          rows[$];
	logic [index_pkg::INDEX_WIDTH-1:0] expected[$];
	int                                errors = 0;
	int                                pass_cmds = 0;
	int                                fail_cmds = 0;
	int                                cycles = 0;
	int                                cycle_limit = 1000000;

	index_unit #(.lane_id(test_lane)) dut (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Run limit, sized from the command table
	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: no completion within %0d cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check_value(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic void add_row(input logic [1:0] mode, input logic [7:0] base,
			input logic [7:0] window, input logic [7:0] length, input logic [7:0] konst,
			input logic [3:0] thread, input logic [1:0] sel_a, input logic [1:0] sel_b,
			input logic [1:0] sel_c, input logic swap, input logic sign,
			input logic [15:0] mask, input logic rand_stall, input int count);
		cmd_row_t r;
		r = '{mode, base, window, length, konst, thread, sel_a, sel_b, sel_c,
			swap, sign, mask, rand_stall, count};
		rows.push_back(r);
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [7:0] calc_index(input cmd_row_t r, input logic [7:0] raw);
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] m;
		case (r.sel_a)
			2'd0: a = 8'(r.thread);
			2'd1: a = r.konst;
			2'd2: a = raw;
			default: a = 8'd0;
		endcase
		case (r.sel_b)
			2'd0: b = 8'd0;
			2'd1: b = r.konst;
			2'd2: b = raw;
			default: b = 8'(test_lane);
		endcase
		case (r.sel_c)
			2'd0: c = 8'(r.thread);
			2'd1: c = r.konst;
			2'd2: c = raw;
			default: c = 8'(test_lane);
		endcase
		m = 8'(a * b);   // Mod 256
		if (r.swap) begin
			return r.sign ? 8'(c - m) : 8'(c + m);
		end
		return r.sign ? 8'(m - c) : 8'(m + c);
	endfunction

	function automatic void build_expected(input cmd_row_t r);
		int win;
		int top;
		expected.delete();
		if (r.mode == index_pkg::MODE_SINGLE) begin
			expected.push_back(calc_index(r, r.base));
		end else if (r.mode == index_pkg::MODE_SLICE) begin
			win = (r.window == 8'd0) ? 1 : int'(r.window);
			for (int k = 0; k < int'(r.length); k++) begin
				expected.push_back(calc_index(r, 8'(int'(r.base) + k % win)));
			end
		end else begin
			top = (int'(r.length) < index_pkg::MASK_WIDTH) ?
				int'(r.length) : index_pkg::MASK_WIDTH;
			for (int p = 0; p < top; p++) begin
				if (r.mask[p]) begin
					expected.push_back(calc_index(r, 8'(int'(r.base) + p)));
				end
			end
		end
	endfunction

	////////////////////////////////////////////////////////////
	// One command through the handshake

	task automatic run_command(input int i);
		cmd_row_t r;
		int got;
		int errs_start;
		bit acked;
		bit captured;
		r = rows[i];
		errs_start = errors;
		build_expected(r);
		check_value(expected.size(), r.count, "model index count");
		cmd_mode   = r.mode;
		cmd_base   = r.base;
		cmd_window = r.window;
		cmd_length = r.length;
		cmd_const  = r.konst;
		cmd_thread = r.thread;
		cmd_sel_a  = r.sel_a;
		cmd_sel_b  = r.sel_b;
		cmd_sel_c  = r.sel_c;
		cmd_swap   = r.swap;
		cmd_sign   = r.sign;
		cmd_mask   = r.mask;
		cmd_req    = 1'b1;
		got = 0;
		acked = 1'b0;
		captured = 1'b0;
		while (!acked) begin
			@(posedge clock);
			#1;
			if (cmd_ack) begin
				acked = 1'b1;
			end else begin
				// Busy stays up from capture until ack
				if (captured) begin
					check_value(busy, 1, "busy");
				end
				captured = captured | busy;
				stall = r.rand_stall && ($urandom_range(0, 1) == 1);
				if (out_valid && !stall) begin   // Taken at the next edge
					if (got < expected.size()) begin
						check_value(out_index, expected[got], "out_index");
						check_value(out_last, int'(got == expected.size() - 1), "out_last");
					end else begin
						$display("ERROR @%0t: extra index %0d after the run", $time, out_index);
						errors++;
					end
					got++;
				end
			end
		end
		check_value(int'(captured), 1, "busy seen before ack");
		check_value(got, r.count, "indices accepted before ack");
		stall = 1'b0;

		// Requester keeps req up a little longer
		repeat (2) begin
			@(posedge clock);
			#1;
			check_value(cmd_ack, 1, "cmd_ack with cmd_req high");
		end
		cmd_req = 1'b0;
		while (cmd_ack) begin
			@(posedge clock);
			#1;
		end
		if (errors == errs_start) begin
			pass_cmds++;
		end else begin
			fail_cmds++;
		end
		$display("Command %0d mode %0d: %0d of %0d indices, %s", i, r.mode, got, r.count,
			(errors == errs_start) ? "pass" : "fail");
	endtask

	initial begin
		void'($urandom(65970));
		reset      = 1'b1;
		cmd_req    = 1'b0;
		cmd_mode   = '0;
		cmd_base   = '0;
		cmd_window = '0;
		cmd_length = '0;
		cmd_const  = '0;
		cmd_thread = '0;
		cmd_sel_a  = '0;
		cmd_sel_b  = '0;
		cmd_sel_c  = '0;
		cmd_swap   = 1'b0;
		cmd_sign   = 1'b0;
		cmd_mask   = '0;
		stall      = 1'b0;

		// mode base win len const thr sel_a sel_b sel_c swap sign mask stall count
		add_row(2'd0, 8'd10, 8'd0, 8'd1, 8'd5, 4'd7, 2'd0, 2'd1, 2'd2, 0, 0, 16'h0, 0, 1);
		add_row(2'd0, 8'd20, 8'd0, 8'd1, 8'd3, 4'd2, 2'd2, 2'd3, 2'd1, 1, 1, 16'h0, 0, 1);
		add_row(2'd0, 8'd30, 8'd0, 8'd1, 8'd9, 4'd5, 2'd1, 2'd0, 2'd0, 0, 1, 16'h0, 0, 1);
		add_row(2'd0, 8'd40, 8'd0, 8'd1, 8'd0, 4'd1, 2'd3, 2'd2, 2'd3, 1, 0, 16'h0, 0, 1);
		add_row(2'd1, 8'd100, 8'd3, 8'd7, 8'd1, 4'd0, 2'd2, 2'd1, 2'd0, 0, 0, 16'h0, 0, 7);
		add_row(2'd1, 8'd40, 8'd5, 8'd5, 8'd0, 4'd3, 2'd0, 2'd3, 2'd2, 0, 0, 16'h0, 1, 5);
		add_row(2'd1, 8'd250, 8'd20, 8'd9, 8'd200, 4'd0, 2'd1, 2'd1, 2'd2, 0, 0, 16'h0, 1, 9);
		add_row(2'd2, 8'd0, 8'd0, 8'd16, 8'd2, 4'd0, 2'd2, 2'd1, 2'd1, 0, 1, 16'h8421, 0, 4);
		add_row(2'd2, 8'd0, 8'd0, 8'd16, 8'd0, 4'd15, 2'd2, 2'd3, 2'd0, 1, 1, 16'hFFFF, 1, 16);
		add_row(2'd2, 8'd200, 8'd0, 8'd6, 8'd0, 4'd0, 2'd0, 2'd0, 2'd2, 0, 0, 16'hF0F3, 0, 4);
		add_row(2'd2, 8'd8, 8'd0, 8'd16, 8'd0, 4'd0, 2'd2, 2'd1, 2'd1, 0, 0, 16'h0000, 0, 0);
		add_row(2'd1, 8'd8, 8'd4, 8'd0, 8'd0, 4'd0, 2'd2, 2'd1, 2'd1, 0, 0, 16'h0, 0, 0);
		add_row(2'd2, 8'd60, 8'd0, 8'd40, 8'd7, 4'd0, 2'd2, 2'd2, 2'd1, 0, 1, 16'hC003, 1, 4);

		cycle_limit = 200;
		foreach (rows[i]) begin
			cycle_limit += (int'(rows[i].length) + 4) * 4;
		end

		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		@(posedge clock);
		#1;

		// Each command starts right after the previous release
		foreach (rows[i]) begin
			run_command(i);
		end

		if (dut.u_asserts.failures != 0) begin
			$display("Bound assertions failed %0d times", dut.u_asserts.failures);
			errors += int'(dut.u_asserts.failures);
		end
		$display("Commands passed: %0d, failed: %0d, check errors: %0d",
			pass_cmds, fail_cmds, errors);
		if (fail_cmds == 0 && errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
